/* design/hsio_pkg.sv */
// hsio bank package: lane, analog settings and axi4-lite types with shared constants
`default_nettype none

package hsio_pkg;

	// lane geometry
	localparam int LANES    = 4;
	localparam int WORD_LEN = 20;

	typedef logic [WORD_LEN-1:0] lane_word_t;
	typedef lane_word_t [LANES-1:0] lane_bus_t;  // 80 bits, lane 0 in the low word

	// analog settings, msb first as the transceiver port packs them
	typedef struct packed {
		logic [3:0] rx_eqctrl;
		logic [2:0] rx_eqdcgain;
		logic [4:0] tx_preemp_0t;
		logic [4:0] tx_preemp_1t;
		logic [4:0] tx_preemp_2t;
		logic [2:0] tx_vodctrl;
	} analog_params_t;

	localparam logic [2:0] VOD_LIMIT = 3'd6;  // highest drive level accepted
	localparam int RECO_BUSY_CYCLES  = 6;
	localparam int RECO_WAIT_CYCLES  = 16;
	localparam int RECO_BUSY_W       = $clog2(RECO_BUSY_CYCLES + 1);
	localparam int RECO_WAIT_W       = $clog2(RECO_WAIT_CYCLES + 1);

	// fifo error stretching, rx fifos low, tx fifos high
	localparam logic [11:0] STRETCH_CYCLES = 12'd64;
	localparam int ERR_W = 2 * LANES;

	// axi4-lite
	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	typedef struct packed {
		logic                   awvalid;
		logic [AXIL_ADDR_W-1:0] awaddr;
		logic                   wvalid;
		logic [AXIL_DATA_W-1:0] wdata;
		logic [AXIL_STRB_W-1:0] wstrb;
		logic                   bready;
		logic                   arvalid;
		logic [AXIL_ADDR_W-1:0] araddr;
		logic                   rready;
	} axil_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic                   bvalid;
		logic [1:0]             bresp;
		logic                   arready;
		logic                   rvalid;
		logic [AXIL_DATA_W-1:0] rdata;
		logic [1:0]             rresp;
	} axil_rsp_t;

	// register map
	localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 4'h0;
	localparam logic [AXIL_ADDR_W-1:0] REG_NEWP   = 4'h4;
	localparam logic [AXIL_ADDR_W-1:0] REG_PARAMS = 4'h8;
	localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 4'hC;

	// reconfig controller states
	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		WRITE_WAIT,
		READ,
		READ_WAIT
	} reco_state_t;

endpackage

`default_nettype wire

/* design/hsio_reco_fsm.sv */
// reconfig controller: sequences a settings write, timed wait, readback and second wait
`default_nettype none
`timescale 1ns/1ps

module hsio_reco_fsm (
	input  wire                      clk_in,
	input  wire                      arst_out,
	input  wire                      write_go,
	input  wire                      read_go,
	input  wire hsio_pkg::analog_params_t new_params,
	input  wire                      timer_max,
	input  wire                      busy,
	input  wire                      data_valid,
	input  wire hsio_pkg::analog_params_t readback,
	output logic                     timer_clr,
	output logic                     write_all,
	output logic                     read,
	output logic                     reco_busy,
	output hsio_pkg::analog_params_t analog_params
);

	import hsio_pkg::*;

	reco_state_t state_q;

	// timer held in clear outside the two wait states
	assign timer_clr = (state_q == IDLE) || (state_q == WRITE) || (state_q == READ);
	assign reco_busy = (state_q != IDLE);

	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			state_q       <= IDLE;
			write_all     <= 1'b0;
			read          <= 1'b0;
			analog_params <= '0;
		end else begin
			write_all <= 1'b0;  // strobes last one cycle
			read      <= 1'b0;
			case (state_q)
				IDLE: begin
					// write wins, go bits only looked at here
					if (write_go) begin
						state_q       <= WRITE;
						write_all     <= 1'b1;       // high during WRITE
						analog_params <= new_params;  // drives the store input
					end else if (read_go) begin
						state_q <= READ;
						read    <= 1'b1;
					end
				end
				WRITE: begin
					state_q <= WRITE_WAIT;
				end
				WRITE_WAIT: begin
					// full wait and the store settled, then read back
					if (timer_max && !busy) begin
						state_q <= READ;
						read    <= 1'b1;
					end
				end
				READ: begin
					state_q <= READ_WAIT;
				end
				READ_WAIT: begin
					if (timer_max) begin
						if (data_valid) begin
							analog_params <= readback;  // confirmed value, vod clamped
						end
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/hsio_reco_timer.sv */
// reconfig wait timer: saturating counter that flags when the wait has run out
`default_nettype none
`timescale 1ns/1ps

module hsio_reco_timer (
	input  wire  clk_in,
	input  wire  arst_out,
	input  wire  timer_clr,
	output logic timer_max
);

	import hsio_pkg::*;

	logic [RECO_WAIT_W-1:0] count_q;

	// counts up from the end of the clear and sticks at the limit
	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			count_q <= '0;
		end else if (timer_clr) begin
			count_q <= '0;
		end else if (!timer_max) begin
			count_q <= count_q + 1'b1;
		end
	end

	assign timer_max = (count_q == RECO_WAIT_W'(RECO_WAIT_CYCLES));  // stays up until cleared

endmodule

`default_nettype wire

/* design/hsio_analog_store.sv */
// analog settings store: reconfig port model with vod clamp and post-write busy time
`default_nettype none
`timescale 1ns/1ps

module hsio_analog_store (
	input  wire                      clk_in,
	input  wire                      arst_out,
	input  wire                      write_all,
	input  wire hsio_pkg::analog_params_t params,
	input  wire                      read,
	output logic                     busy,
	output logic                     data_valid,
	output hsio_pkg::analog_params_t readback
);

	import hsio_pkg::*;

	logic [RECO_BUSY_W-1:0] busy_cnt_q;  // cycles of busy left
	analog_params_t         stored_q;    // settings held by the channel
	analog_params_t         clamped;
	logic                   rd_ok;

	// drive level above the limit is not accepted, pin it
	always_comb begin
		clamped = params;
		if (params.tx_vodctrl > VOD_LIMIT) begin
			clamped.tx_vodctrl = VOD_LIMIT;
		end
	end

	assign busy  = (busy_cnt_q != '0);
	assign rd_ok = read && !busy;  // reads during busy are ignored

	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			busy_cnt_q <= '0;
			data_valid <= 1'b0;
			stored_q   <= '0;
		end else if (write_all) begin
			busy_cnt_q <= RECO_BUSY_W'(RECO_BUSY_CYCLES);
			data_valid <= 1'b0;  // old readback is stale now
			stored_q   <= clamped;
		end else begin
			if (busy) begin
				busy_cnt_q <= busy_cnt_q - 1'b1;
			end
			if (rd_ok) begin
				data_valid <= 1'b1;  // held until the next write
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (rd_ok) begin
			readback <= stored_q;
		end
	end

endmodule

`default_nettype wire

/* design/hsio_axil_regs.sv */
// axi4-lite register slave: control pulses, new settings, readback and status
`default_nettype none
`timescale 1ns/1ps

module hsio_axil_regs (
	input  wire                      clk_in,
	input  wire                      arst_out,
	input  wire hsio_pkg::axil_req_t axil_req,
	input  wire                      reco_busy,
	input  wire hsio_pkg::analog_params_t analog_params,
	input  wire [hsio_pkg::ERR_W-1:0] err_flags,
	output hsio_pkg::axil_rsp_t      axil_rsp,
	output logic                     write_go,
	output logic                     read_go,
	output logic                     inject_pulse,
	output logic                     loopback,
	output hsio_pkg::analog_params_t new_params
);

	import hsio_pkg::*;

	logic                   wr_ready_q;  // awready and wready together
	logic                   bvalid_q;
	logic                   arready_q;
	logic                   rvalid_q;
	logic [AXIL_DATA_W-1:0] rdata_q;
	logic                   wr_hs;
	logic                   ar_hs;
	logic [AXIL_DATA_W-1:0] wmask;        // byte strobes widened to bits
	logic [AXIL_DATA_W-1:0] newp_merged;
	logic [AXIL_DATA_W-1:0] rd_mux;

	assign wr_hs = wr_ready_q && axil_req.awvalid && axil_req.wvalid;
	assign ar_hs = arready_q && axil_req.arvalid;

	always_comb begin
		for (int b = 0; b < AXIL_STRB_W; b++) begin
			wmask[8*b +: 8] = {8{axil_req.wstrb[b]}};
		end
	end

	assign newp_merged = ({7'h0, new_params} & ~wmask) | (axil_req.wdata & wmask);

	//////////////////////////////
	// write channel
	//////////////////////////////
	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			wr_ready_q <= 1'b0;
			bvalid_q   <= 1'b0;
		end else if (wr_hs) begin
			wr_ready_q <= 1'b0;
			bvalid_q   <= 1'b1;  // response the cycle after
		end else begin
			if (bvalid_q && axil_req.bready) begin
				bvalid_q <= 1'b0;
			end
			// one-cycle ready once address and data both wait, none while b pending
			wr_ready_q <= axil_req.awvalid && axil_req.wvalid && !wr_ready_q && !bvalid_q;
		end
	end

	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			write_go     <= 1'b0;
			read_go      <= 1'b0;
			inject_pulse <= 1'b0;
			loopback     <= 1'b0;
			new_params   <= '0;
		end else begin
			write_go     <= 1'b0;
			read_go      <= 1'b0;
			inject_pulse <= 1'b0;
			if (wr_hs) begin
				case (axil_req.awaddr)
					REG_CTRL: begin
						if (axil_req.wstrb[0]) begin
							write_go     <= axil_req.wdata[0];
							read_go      <= axil_req.wdata[1];
							loopback     <= axil_req.wdata[2];  // level
							inject_pulse <= axil_req.wdata[3];
						end
					end
					REG_NEWP: new_params <= analog_params_t'(newp_merged[24:0]);
					default: ;  // writes elsewhere dropped
				endcase
			end
		end
	end

	//////////////////////////////
	// read channel
	//////////////////////////////
	always_comb begin
		case (axil_req.araddr)
			REG_NEWP:   rd_mux = {7'h0, new_params};
			REG_PARAMS: rd_mux = {7'h0, analog_params};
			REG_STATUS: rd_mux = {16'h0, err_flags, 7'h0, reco_busy};
			default:    rd_mux = '0;  // ctrl is write-only
		endcase
	end

	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end else if (ar_hs) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b1;
		end else begin
			if (rvalid_q && axil_req.rready) begin
				rvalid_q <= 1'b0;
			end
			arready_q <= !rvalid_q || axil_req.rready;  // open again once r is taken
		end
	end

	always_ff @(posedge clk_in) begin
		if (ar_hs) begin
			rdata_q <= rd_mux;
		end
	end

	assign axil_rsp = '{
		awready: wr_ready_q,
		wready:  wr_ready_q,
		bvalid:  bvalid_q,
		bresp:   2'b00,
		arready: arready_q,
		rvalid:  rvalid_q,
		rdata:   rdata_q,
		rresp:   2'b00
	};

endmodule

`default_nettype wire

/* design/hsio_lane_path.sv */
// lane datapaths: per-lane bit reversal, tx error injection and serial loopback
`default_nettype none
`timescale 1ns/1ps

module hsio_lane_path (
	input  wire                 clk_in,
	input  wire                 arst_out,
	input  wire hsio_pkg::lane_bus_t tx_data,
	input  wire hsio_pkg::lane_bus_t rx_lanes,
	input  wire                 inject_pulse,
	input  wire                 loopback,
	output hsio_pkg::lane_bus_t tx_lanes,
	output hsio_pkg::lane_bus_t rx_data
);

	import hsio_pkg::*;

	lane_bus_t tx_rev;
	lane_bus_t rx_src;
	lane_bus_t rx_rev;

	// serializer sends lsb first, so flip each word end for end
	function automatic lane_bus_t rev_bus(input lane_bus_t din);
		lane_bus_t dout;
		for (int l = 0; l < LANES; l++) begin
			for (int b = 0; b < WORD_LEN; b++) begin
				dout[l][b] = din[l][WORD_LEN-1-b];
			end
		end
		return dout;
	endfunction

	//////////////////////////////
	// transmit
	//////////////////////////////
	always_comb begin
		tx_rev       = rev_bus(tx_data);
		tx_rev[0][0] = tx_rev[0][0] ^ inject_pulse;  // single bit error, lane 0 only
	end

	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			tx_lanes <= '0;
		end else begin
			tx_lanes <= tx_rev;
		end
	end

	//////////////////////////////
	// receive
	//////////////////////////////
	assign rx_src = loopback ? tx_lanes : rx_lanes;  // loopback taps the tx output regs
	assign rx_rev = rev_bus(rx_src);

	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			rx_data <= '0;
		end else begin
			rx_data <= rx_rev;
		end
	end

endmodule

`default_nettype wire

/* design/hsio_err_stretch.sv */
// fifo error stretcher: synchronizes each error pulse and holds a flag for a while
`default_nettype none
`timescale 1ns/1ps

module hsio_err_stretch (
	input  wire                        clk_in,
	input  wire                        arst_out,
	input  wire  [hsio_pkg::ERR_W-1:0] fifo_err,
	output wire  [hsio_pkg::ERR_W-1:0] err_flags
);

	import hsio_pkg::*;

	logic [ERR_W-1:0] sync_a_q;
	logic [ERR_W-1:0] sync_b_q;

	// two flop synchronizer on all inputs
	always_ff @(posedge clk_in or posedge arst_out) begin
		if (arst_out) begin
			sync_a_q <= '0;
			sync_b_q <= '0;
		end else begin
			sync_a_q <= fifo_err;
			sync_b_q <= sync_a_q;
		end
	end

	for (genvar i = 0; i < ERR_W; i++) begin : g_str
		logic [11:0] cnt_q;
		always_ff @(posedge clk_in or posedge arst_out) begin
			if (arst_out) begin
				cnt_q <= '0;
			end else if (sync_b_q[i]) begin
				cnt_q <= STRETCH_CYCLES;  // a new pulse restarts the stretch
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
		assign err_flags[i] = |cnt_q;
	end

endmodule

`default_nettype wire

/* design/hsio_bank.sv */
// hsio bank top: register slave, reconfig controller, store, lane paths and error stretcher
`default_nettype none
`timescale 1ns/1ps

module hsio_bank (
	input  wire                        clk_in,
	input  wire                        arst_out,
	input  wire hsio_pkg::axil_req_t   axil_req,
	output hsio_pkg::axil_rsp_t        axil_rsp,
	input  wire hsio_pkg::lane_bus_t   tx_data,
	output hsio_pkg::lane_bus_t        tx_lanes,
	input  wire hsio_pkg::lane_bus_t   rx_lanes,
	output hsio_pkg::lane_bus_t        rx_data,
	input  wire [hsio_pkg::ERR_W-1:0]  fifo_err
);

	import hsio_pkg::*;

	// register slave outputs
	logic           write_go;
	logic           read_go;
	logic           inject_pulse;
	logic           loopback;
	analog_params_t new_params;

	// controller, timer and store
	logic           write_all;
	logic           read;
	logic           timer_clr;
	logic           timer_max;
	logic           reco_busy;
	analog_params_t analog_params;
	logic           busy;
	logic           data_valid;
	analog_params_t readback;

	wire [ERR_W-1:0] err_flags;

	hsio_axil_regs u_axil_regs (
		.clk_in        (clk_in),
		.arst_out      (arst_out),
		.axil_req      (axil_req),
		.reco_busy     (reco_busy),
		.analog_params (analog_params),
		.err_flags     (err_flags),
		.axil_rsp      (axil_rsp),
		.write_go      (write_go),
		.read_go       (read_go),
		.inject_pulse  (inject_pulse),
		.loopback      (loopback),
		.new_params    (new_params)
	);

	hsio_reco_fsm u_reco_fsm (
		.clk_in        (clk_in),
		.arst_out      (arst_out),
		.write_go      (write_go),
		.read_go       (read_go),
		.new_params    (new_params),
		.timer_max     (timer_max),
		.busy          (busy),
		.data_valid    (data_valid),
		.readback      (readback),
		.timer_clr     (timer_clr),
		.write_all     (write_all),
		.read          (read),
		.reco_busy     (reco_busy),
		.analog_params (analog_params)
	);

	hsio_reco_timer u_reco_timer (
		.clk_in    (clk_in),
		.arst_out  (arst_out),
		.timer_clr (timer_clr),
		.timer_max (timer_max)
	);

	// store takes the controller's captured settings
	hsio_analog_store u_analog_store (
		.clk_in     (clk_in),
		.arst_out   (arst_out),
		.write_all  (write_all),
		.params     (analog_params),
		.read       (read),
		.busy       (busy),
		.data_valid (data_valid),
		.readback   (readback)
	);

	hsio_lane_path u_lane_path (
		.clk_in       (clk_in),
		.arst_out     (arst_out),
		.tx_data      (tx_data),
		.rx_lanes     (rx_lanes),
		.inject_pulse (inject_pulse),
		.loopback     (loopback),
		.tx_lanes     (tx_lanes),
		.rx_data      (rx_data)
	);

	hsio_err_stretch u_err_stretch (
		.clk_in    (clk_in),
		.arst_out  (arst_out),
		.fifo_err  (fifo_err),
		.err_flags (err_flags)
	);

endmodule

`default_nettype wire

/* bench/hsio_bank_checker.sv */
// hsio bank checker: predicts lane words and register reads at the dut ports and counts errors
`default_nettype none
`timescale 1ns/1ps

module hsio_bank_checker (
	input wire                      clk_in,
	input wire                      arst_out,
	input wire hsio_pkg::axil_req_t axil_req,
	input wire hsio_pkg::axil_rsp_t axil_rsp,
	input wire hsio_pkg::lane_bus_t tx_data,
	input wire hsio_pkg::lane_bus_t tx_lanes,
	input wire hsio_pkg::lane_bus_t rx_lanes,
	input wire hsio_pkg::lane_bus_t rx_data
);

	import hsio_pkg::*;

	localparam int         HANG_LIMIT = 32;     // cycles a transaction may stay open
	localparam logic [1:0] RESP_OKAY  = 2'b00;  // only response the bank gives

	typedef struct packed {
		logic [31:0] value;
		logic [31:0] mask;
		logic        flag_win;  // flag bits judged by time since the error pulse
	} rd_exp_t;

	string     test_name = "none";
	int        errors    = 0;
	int        checks    = 0;
	rd_exp_t   rd_exp_q[$];
	rd_exp_t   cur_exp;
	lane_bus_t exp_tx;             // what the next edge puts on tx_lanes
	lane_bus_t exp_rx;
	logic      m_loop;             // loopback level as the bank holds it
	logic      m_inj;              // inject pulse as the bank holds it
	int        cyc       = 0;      // falling edges seen
	int        pulse_cyc = 0;
	int        pulse_idx = 0;
	int        ar_elapsed;
	logic      wr_open;
	logic      rd_open;
	int        wr_wait;
	int        rd_wait;

	// each lane word sent end for end
	function automatic lane_bus_t flip_lanes(input lane_bus_t b);
		lane_bus_t r;
		for (int l = 0; l < LANES; l++) begin
			r[l] = {<<{b[l]}};
		end
		return r;
	endfunction

	//////////////////////////////
	// called from the testbench
	//////////////////////////////
	task automatic set_test(input string name);
		test_name = name;
	endtask

	task automatic expect_read(input logic [31:0] value, input logic [31:0] mask,
		input logic flag_win);
		rd_exp_t e;
		e.value    = value;
		e.mask     = mask;
		e.flag_win = flag_win;
		rd_exp_q.push_back(e);
	endtask

	task automatic arm_stretch(input int idx);
		pulse_idx = idx;
		pulse_cyc = cyc;
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("error in %s: %s", test_name, msg);
	endtask

	task automatic check_eq(input string what, input logic [79:0] exp, input logic [79:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s %s expected %0h actual %0h", test_name, what, exp, act);
		end
	endtask

	//////////////////////////////
	// sampling on the falling edge
	//////////////////////////////
	always @(negedge clk_in) begin
		cyc++;
		if (arst_out) begin
			exp_tx  = '0;  // bank outputs clear in reset
			exp_rx  = '0;
			m_loop  = 1'b0;
			m_inj   = 1'b0;
			wr_open = 1'b0;
			rd_open = 1'b0;
			wr_wait = 0;
			rd_wait = 0;
		end else begin
			check_eq("tx_lanes", exp_tx, tx_lanes);
			check_eq("rx_data", exp_rx, rx_data);
			// rx first, it takes the tx word currently on the pins
			exp_rx = flip_lanes(m_loop ? exp_tx : rx_lanes);
			exp_tx = flip_lanes(tx_data);
			exp_tx[0][0] = exp_tx[0][0] ^ m_inj;
			m_inj = 1'b0;  // pulse lasts one cycle
			if (axil_req.awvalid && axil_req.wvalid && axil_rsp.awready && axil_rsp.wready) begin
				if (axil_req.awaddr == REG_CTRL && axil_req.wstrb[0]) begin
					m_loop = axil_req.wdata[2];
					m_inj  = axil_req.wdata[3];
				end
			end

			// read data against the queued expectation
			if (axil_req.arvalid && axil_rsp.arready) ar_elapsed = cyc - pulse_cyc;
			if (axil_rsp.rvalid && axil_req.rready) begin
				check_eq("rresp", {78'h0, RESP_OKAY}, {78'h0, axil_rsp.rresp});
				if (rd_exp_q.size() == 0) begin
					report_error("read response arrived with no expected value queued");
				end else begin
					cur_exp = rd_exp_q.pop_front();
					if (cur_exp.flag_win) begin
						cur_exp.mask[15:8]  = 8'hff;
						cur_exp.value[15:8] = 8'h00;
						if (ar_elapsed >= 5 && ar_elapsed <= int'(STRETCH_CYCLES)) begin
							cur_exp.value[8+pulse_idx] = 1'b1;
						end else if (ar_elapsed < int'(STRETCH_CYCLES) + 7) begin
							cur_exp.mask[8+pulse_idx] = 1'b0;  // rise or fall edge, either value
						end
					end
					check_eq("rdata", {48'h0, cur_exp.value & cur_exp.mask},
						{48'h0, axil_rsp.rdata & cur_exp.mask});
				end
			end

			// transactions that never complete
			if (axil_req.awvalid) wr_open = 1'b1;
			if (axil_rsp.bvalid && axil_req.bready) begin
				check_eq("bresp", {78'h0, RESP_OKAY}, {78'h0, axil_rsp.bresp});
				wr_open = 1'b0;
				wr_wait = 0;
			end else if (wr_open) begin
				wr_wait++;
				if (wr_wait == HANG_LIMIT) begin
					report_error($sformatf("write got no response in %0d cycles", HANG_LIMIT));
				end
			end
			if (axil_req.arvalid) rd_open = 1'b1;
			if (axil_rsp.rvalid && axil_req.rready) begin
				rd_open = 1'b0;
				rd_wait = 0;
			end else if (rd_open) begin
				rd_wait++;
				if (rd_wait == HANG_LIMIT) begin
					report_error($sformatf("read got no response in %0d cycles", HANG_LIMIT));
				end
			end
		end
	end

endmodule

`default_nettype wire

/* bench/hsio_bank_tb.sv */
// hsio bank testbench: runs register, lane and fifo error vectors from a file against the bank
`default_nettype none
`timescale 1ns/1ps

module hsio_bank_tb;

	import hsio_pkg::*;

	localparam int CLK_HALF     = 50;  // 100 ns period
	localparam int DRIVE_DLY    = 10;  // inputs change this long after the rising edge
	localparam int MAX_POLLS    = 40;
	localparam int RREADY_DLY   = 2;   // master holds off rready in the stretch reads
	localparam int STRETCH_SPAN = int'(STRETCH_CYCLES) + 16;
	localparam int MARGIN       = 200;

	typedef struct packed {
		logic [7:0]  op;  // command letter
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
	} vec_cmd_t;

	logic             clk_in;
	logic             arst_out;
	axil_req_t        axil_req;
	axil_rsp_t        axil_rsp;
	lane_bus_t        tx_data;
	lane_bus_t        tx_lanes;
	lane_bus_t        rx_lanes;
	lane_bus_t        rx_data;
	logic [ERR_W-1:0] fifo_err;

	vec_cmd_t    cmd_q[$];
	string       name_q[$];   // test names, indexed by the T commands
	logic [31:0] lcg_state   = 32'hc1df689e;
	int          cycle       = 0;
	int          cycle_limit = MARGIN;

	hsio_bank u_hsio_bank (
		.clk_in   (clk_in),
		.arst_out (arst_out),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.tx_data  (tx_data),
		.tx_lanes (tx_lanes),
		.rx_lanes (rx_lanes),
		.rx_data  (rx_data),
		.fifo_err (fifo_err)
	);

	hsio_bank_checker u_checker (
		.clk_in   (clk_in),
		.arst_out (arst_out),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.tx_data  (tx_data),
		.tx_lanes (tx_lanes),
		.rx_lanes (rx_lanes),
		.rx_data  (rx_data)
	);

	initial begin
		clk_in = 1'b0;
		forever #CLK_HALF clk_in = ~clk_in;
	end

	always @(posedge clk_in) cycle <= cycle + 1;

	//////////////////////////////
	// helpers
	//////////////////////////////
	task automatic tick();
		@(posedge clk_in);
		#DRIVE_DLY;
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic rand_bus(output lane_bus_t b);
		for (int l = 0; l < LANES; l++) begin
			lcg_state = lcg_step(lcg_state);
			b[l] = lcg_state[31:12];  // high bits, the low ones repeat quickly
		end
	endtask

	// worst case cycles per command, sets the run limit
	function automatic int cmd_cost(input logic [7:0] op, input logic [31:0] a);
		case (op)
			"W": return 12;
			"R": return 12 + RREADY_DLY;
			"P": return MAX_POLLS * 8;
			"B": return int'(a) + 4;
			"E": return STRETCH_SPAN + 40;
			default: return 0;
		endcase
	endfunction

	task automatic load_vectors();
		int       fd;
		int       n;
		string    line;
		string    word;
		string    tname;
		vec_cmd_t cmd;
		fd = $fopen("bench/hsio_bank_vectors.txt", "r");
		if (fd == 0) begin
			u_checker.report_error("vector file bench/hsio_bank_vectors.txt could not be opened");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n <= 1 || line.getc(0) == "#") continue;  // blank or comment
			cmd = '0;
			cmd.op = line.getc(0);
			if (cmd.op == "T") begin
				n = $sscanf(line, "%s %s", word, tname);
				cmd.a = name_q.size();
				name_q.push_back(tname);
			end else begin
				n = $sscanf(line, "%s %h %h %h", word, cmd.a, cmd.b, cmd.c);
			end
			cycle_limit += cmd_cost(cmd.op, cmd.a);
			cmd_q.push_back(cmd);
		end
		$fclose(fd);
		if (cmd_q.size() == 0) u_checker.report_error("vector file holds no commands");
	endtask

	//////////////////////////////
	// axi4-lite master
	//////////////////////////////
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hf;
		axil_req.bready  = 1'b1;
		while (!(axil_rsp.awready && axil_rsp.wready)) tick();
		tick();  // address and data taken here
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		while (!axil_rsp.bvalid) tick();
		tick();
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, input int hold, output logic [31:0] data);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		axil_req.rready  = 1'b0;
		while (!axil_rsp.arready) tick();
		tick();
		axil_req.arvalid = 1'b0;
		while (!axil_rsp.rvalid) tick();
		repeat (hold) tick();  // response waits on the master
		data = axil_rsp.rdata;
		axil_req.rready = 1'b1;
		tick();
		axil_req.rready = 1'b0;
	endtask

	//////////////////////////////
	// commands
	//////////////////////////////
	task automatic poll_idle();
		logic [31:0] st;
		int          n;
		st = 32'h1;
		n  = 0;
		while (st[0] && n < MAX_POLLS) begin
			u_checker.expect_read(32'h0, 32'h0, 1'b0);  // busy bit steers the loop only
			axil_read(REG_STATUS, 0, st);
			n++;
		end
		if (st[0]) begin
			u_checker.report_error($sformatf("reco_busy still set after %0d status polls", MAX_POLLS));
		end
	endtask

	task automatic lane_burst(input int count);
		lane_bus_t b;
		for (int i = 0; i < count; i++) begin
			rand_bus(b);
			tx_data = b;
			rand_bus(b);
			rx_lanes = b;  // ignored by the path while looped back
			tick();
		end
	endtask

	task automatic pulse_fifo_err(input int idx);
		logic [31:0] st;
		int          start;
		fifo_err      = '0;
		fifo_err[idx] = 1'b1;
		u_checker.arm_stretch(idx);
		start = cycle;
		tick();
		fifo_err = '0;  // one cycle wide
		while (cycle - start < STRETCH_SPAN) begin
			u_checker.expect_read(32'h0, 32'h0000ffff, 1'b1);
			axil_read(REG_STATUS, RREADY_DLY, st);
		end
	endtask

	task automatic run_cmd(input vec_cmd_t cmd);
		logic [31:0] rd;
		case (cmd.op)
			"T": u_checker.set_test(name_q[cmd.a]);
			"W": axil_write(cmd.a[3:0], cmd.b);
			"R": begin
				u_checker.expect_read(cmd.b, cmd.c, 1'b0);
				axil_read(cmd.a[3:0], 0, rd);
			end
			"P": poll_idle();
			"B": lane_burst(int'(cmd.a));
			"E": pulse_fifo_err(int'(cmd.a));
			default: u_checker.report_error($sformatf("unknown vector command %c", cmd.op));
		endcase
	endtask

	//////////////////////////////
	// main sequence and timeout
	//////////////////////////////
	initial begin
		axil_req = '0;
		tx_data  = '0;
		rx_lanes = '0;
		fifo_err = '0;
		arst_out = 1'b1;
		load_vectors();
		repeat (10) @(posedge clk_in);
		#DRIVE_DLY arst_out = 1'b0;
		tick();  // arready comes up
		foreach (cmd_q[i]) run_cmd(cmd_q[i]);
		repeat (4) tick();
		$display("checks %0d, errors %0d", u_checker.checks, u_checker.errors);
		if (u_checker.errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		@(posedge clk_in);  // limit known by now
		while (cycle < cycle_limit) @(posedge clk_in);
		$display("timeout after %0d cycles, checks %0d, errors %0d", cycle_limit,
			u_checker.checks, u_checker.errors);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* hsio_bank.f */
design/hsio_pkg.sv
design/hsio_reco_fsm.sv
design/hsio_reco_timer.sv
design/hsio_analog_store.sv
design/hsio_axil_regs.sv
design/hsio_lane_path.sv
design/hsio_err_stretch.sv
design/hsio_bank.sv
bench/hsio_bank_checker.sv
bench/hsio_bank_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the hsio bank testbench, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module hsio_bank_tb -f hsio_bank.f \
	-o hsio_bank_sim || { echo "build failed"; exit 1; }
./obj_dir/hsio_bank_sim > sim.log 2>&1 || { cat sim.log; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "RESULT: no verdict in log"; exit 1; }
echo "RESULT: PASS"

/* bench/hsio_bank_vectors.txt */
# hsio bank vectors, one command per line, numbers in hex
# T name | W addr data | R addr expected mask | P poll busy | B words | E fifo_err index
T reset_state
R 8 00000000 ffffffff
R c 00000000 ffffffff
T reco_write
W 4 01a2b3c5
W 0 00000001
R c 00000001 00000001
P
R 8 01a2b3c5 ffffffff
T vod_clamp
W 4 00c3d2e7
W 0 00000001
P
R 8 00c3d2e6 ffffffff
T reco_read_only
W 0 00000002
R c 00000001 00000001
P
R 8 00c3d2e6 ffffffff
T lane_direct
B 18
T lane_loopback
W 0 00000004
B 18
T lane_inject
W 0 0000000c
B 8
W 0 00000000
B 6
T fifo_err_stretch
E 2
E 7
